// File: rtl/pdu_config.svh
`ifndef PDU_CONFIG_SVH
`define PDU_CONFIG_SVH

// Check address bases for ck1 and ck2
`define PDU_RF_BASE 32'h0000_1000
`define PDU_DM_BASE 32'h0000_2000

// Datapath status regions, selected by ck0N
`define PDU_STAT_STRIDE 32'h0000_0020
`define PDU_STAT_REGIONS 6

// Run stops on a PC below the low limit or equal to the halt PC
`define PDU_PC_LOW 32'h0000_2ff0
`define PDU_PC_HALT 32'h0000_3fff

// clk cycles with cpu_clk high, one period is twice this plus one
`define CPU_CLK_HALF 50

`endif

// File: rtl/pdu_pkg.sv
package pdu_pkg;

    typedef logic [7:0]  char_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [7:0]  led_t;

    // Region code: 0 absolute, 1 RF, 2 DM, {1, N} status region N
    typedef logic [3:0]  base_sel_t;

    typedef enum logic [4:0] {
        st_idle,
        st_s, st_st, st_ste, st_step, st_step_done,
        st_su, st_sub, st_sub_done,
        st_r, st_ru, st_run_n, st_rs, st_rst_t, st_rst_pulse,
        st_c, st_ck, st_ck0, st_ck_hex, st_ck_done,
        st_a, st_ad, st_add, st_add_done,
        st_b, st_bp_hex, st_bp_done,
        st_run, st_run_done
    } pdu_state_e;

    // Returns 1 for 0-9, a-f, A-F
    function automatic logic hex_value(input char_t c, output nibble_t value);
        logic is_hex;
        is_hex = 1'b1;
        value  = '0;
        if (c >= "0" && c <= "9") begin
            value = nibble_t'(c - "0");
        end else if (c >= "a" && c <= "f") begin
            value = nibble_t'(c - "a" + 8'd10);
        end else if (c >= "A" && c <= "F") begin
            value = nibble_t'(c - "A" + 8'd10);
        end else begin
            is_hex = 1'b0;
        end
        return is_hex;
    endfunction

endpackage

// File: rtl/pdu_ifs.sv
`timescale 1ns/1ps

// Parser to check-address register
interface addr_ctrl_if;
    import pdu_pkg::*;

    logic      addr_clear;
    logic      addr_inc;
    logic      addr_dec;
    logic      base_load;
    base_sel_t base_sel;
    logic      digit_shift;
    char_t     digit;
    logic      commit;

    modport fsm (
        output addr_clear, addr_inc, addr_dec, base_load, base_sel,
        output digit_shift, digit, commit
    );
    modport unit (
        input addr_clear, addr_inc, addr_dec, base_load, base_sel,
        input digit_shift, digit, commit
    );
endinterface

// Parser to breakpoint register
interface bp_ctrl_if;
    import pdu_pkg::*;

    logic  bp_clear;
    logic  bp_shift;
    logic  bp_capture;
    char_t digit;
    logic  bp_hit;

    modport fsm (output bp_clear, bp_shift, bp_capture, digit, input bp_hit);
    modport unit (input bp_clear, bp_shift, bp_capture, digit, output bp_hit);
endinterface

// File: rtl/pdu_cmd_fsm.sv
`timescale 1ns/1ps
`include "pdu_config.svh"

module pdu_cmd_fsm (
    input  logic           clk,
    input  logic           rst,
    input  logic           din_vld,
    input  pdu_pkg::char_t din_data,
    input  logic           ebreak,
    input  pdu_pkg::addr_t current_pc,
    addr_ctrl_if.fsm       addr,
    bp_ctrl_if.fsm         bp,
    output logic           run_en,
    output logic           cpu_rst,
    output pdu_pkg::led_t  led
);
    import pdu_pkg::*;

    pdu_state_e state;
    pdu_state_e state_nxt;
    char_t      stat_idx;
    logic       stat_ok;
    logic       stop;

    // Digit after ck0 picks the status region
    assign stat_idx = din_data - char_t'("0");
    assign stat_ok  = (din_data >= "0") && (stat_idx < `PDU_STAT_REGIONS);

    assign stop = ebreak || bp.bp_hit || (current_pc == `PDU_PC_HALT) ||
                  (current_pc < `PDU_PC_LOW);

    assign addr.digit = din_data;
    assign bp.digit   = din_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt        = state;
        addr.addr_clear  = 1'b0;
        addr.addr_inc    = 1'b0;
        addr.addr_dec    = 1'b0;
        addr.base_load   = 1'b0;
        addr.base_sel    = '0;
        addr.digit_shift = 1'b0;
        addr.commit      = 1'b0;
        bp.bp_clear      = 1'b0;
        bp.bp_shift      = 1'b0;
        bp.bp_capture    = 1'b0;
        case (state)
            st_idle: if (din_vld) begin
                case (din_data)
                    "s": state_nxt = st_s;
                    "r": state_nxt = st_r;
                    "c": state_nxt = st_c;
                    "a": state_nxt = st_a;
                    "b": state_nxt = st_b;
                    default: state_nxt = st_idle;
                endcase
            end

            // s leads to step or sub
            st_s: if (din_vld) begin
                case (din_data)
                    "t": state_nxt = st_st;
                    "u": state_nxt = st_su;
                    default: state_nxt = st_idle;
                endcase
            end
            st_st: if (din_vld) state_nxt = (din_data == "e") ? st_ste : st_idle;
            st_ste: if (din_vld) state_nxt = (din_data == "p") ? st_step : st_idle;
            st_step: if (din_vld) state_nxt = (din_data == ";") ? st_step_done : st_idle;
            st_step_done: begin
                bp.bp_capture = 1'b1;
                state_nxt     = st_run;
            end
            st_su: if (din_vld) state_nxt = (din_data == "b") ? st_sub : st_idle;
            st_sub: if (din_vld) state_nxt = (din_data == ";") ? st_sub_done : st_idle;
            st_sub_done: begin
                addr.addr_dec = 1'b1;
                state_nxt     = st_idle;
            end

            // r leads to run or rst
            st_r: if (din_vld) begin
                case (din_data)
                    "u": state_nxt = st_ru;
                    "s": state_nxt = st_rs;
                    default: state_nxt = st_idle;
                endcase
            end
            st_ru: if (din_vld) state_nxt = (din_data == "n") ? st_run_n : st_idle;
            st_run_n: if (din_vld) state_nxt = (din_data == ";") ? st_run : st_idle;
            st_rs: if (din_vld) state_nxt = (din_data == "t") ? st_rst_t : st_idle;
            st_rst_t: if (din_vld) state_nxt = (din_data == ";") ? st_rst_pulse : st_idle;
            st_rst_pulse: state_nxt = st_idle;

            st_c: if (din_vld) state_nxt = (din_data == "k") ? st_ck : st_idle;
            st_ck: if (din_vld) begin
                state_nxt     = st_ck_hex;
                addr.base_load = 1'b1;
                case (din_data)
                    " ": addr.base_sel = 4'h0;
                    "1": addr.base_sel = 4'h1;
                    "2": addr.base_sel = 4'h2;
                    "0": begin
                        addr.base_load = 1'b0;
                        addr.addr_clear = 1'b1;
                        state_nxt       = st_ck0;
                    end
                    default: begin
                        addr.base_load = 1'b0;
                        state_nxt      = st_idle;
                    end
                endcase
            end
            st_ck0: if (din_vld) begin
                if (stat_ok) begin
                    addr.base_load = 1'b1;
                    addr.base_sel  = {1'b1, stat_idx[2:0]};
                    state_nxt      = st_ck_hex;
                end else begin
                    state_nxt = st_idle;
                end
            end
            // Only ; ends the field, the unit drops non-hex bytes
            st_ck_hex: if (din_vld) begin
                if (din_data == ";") begin
                    state_nxt = st_ck_done;
                end else begin
                    addr.digit_shift = 1'b1;
                end
            end
            st_ck_done: begin
                addr.commit = 1'b1;
                state_nxt   = st_idle;
            end

            st_a: if (din_vld) state_nxt = (din_data == "d") ? st_ad : st_idle;
            st_ad: if (din_vld) state_nxt = (din_data == "d") ? st_add : st_idle;
            st_add: if (din_vld) state_nxt = (din_data == ";") ? st_add_done : st_idle;
            st_add_done: begin
                addr.addr_inc = 1'b1;
                state_nxt     = st_idle;
            end

            st_b: if (din_vld) begin
                if (din_data == "p") begin
                    bp.bp_clear = 1'b1;
                    state_nxt   = st_bp_hex;
                end else begin
                    state_nxt = st_idle;
                end
            end
            st_bp_hex: if (din_vld) begin
                if (din_data == ";") begin
                    state_nxt = st_bp_done;
                end else begin
                    bp.bp_shift = 1'b1;
                end
            end
            st_bp_done: state_nxt = st_idle;

            st_run: if (stop) state_nxt = st_run_done;
            st_run_done: state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    // Clock gen finishes the period already under way
    assign run_en  = (state == st_run) && !stop;
    assign cpu_rst = (state == st_rst_pulse);

    always_comb begin
        case (state)
            st_idle: led = 8'b0001_0000;
            st_run: led = 8'b1100_0000;
            st_step_done: led = 8'b1000_0000;
            default: led = '0;
        endcase
    end

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state) && (state <= state.last()))
        else $error("parser state out of range");

    a_rst_single: assert property (@(posedge clk) disable iff (rst)
        cpu_rst |=> !cpu_rst)
        else $error("cpu_rst held for more than one cycle");

endmodule

// File: rtl/check_addr_unit.sv
`timescale 1ns/1ps
`include "pdu_config.svh"

module check_addr_unit (
    input  logic           clk,
    input  logic           rst,
    addr_ctrl_if.unit      ctl,
    output pdu_pkg::addr_t check_addr
);
    import pdu_pkg::*;

    addr_t   addr_q;
    addr_t   offset_q;
    addr_t   base;
    nibble_t nib;
    logic    is_hex;

    always_comb begin
        is_hex = hex_value(ctl.digit, nib);
    end

    // Region code to base address
    always_comb begin
        if (ctl.base_sel[3]) begin
            base = addr_t'(ctl.base_sel[2:0]) * addr_t'(`PDU_STAT_STRIDE);
        end else begin
            case (ctl.base_sel[1:0])
                2'd1: base = `PDU_RF_BASE;
                2'd2: base = `PDU_DM_BASE;
                default: base = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || ctl.addr_clear) begin
            addr_q   <= '0;
            offset_q <= '0;
        end else if (ctl.base_load) begin
            addr_q   <= base;
            offset_q <= '0;
        end else if (ctl.addr_inc) begin
            addr_q <= addr_q + 32'd1;
        end else if (ctl.addr_dec) begin
            addr_q <= addr_q - 32'd1;
        end else if (ctl.digit_shift && is_hex) begin
            offset_q <= {offset_q[27:0], nib};
        end else if (ctl.commit) begin
            addr_q <= addr_q + offset_q;
        end
    end

    assign check_addr = addr_q;

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ctl.addr_clear, ctl.addr_inc, ctl.addr_dec, ctl.base_load,
                  ctl.digit_shift, ctl.commit}))
        else $error("more than one check address strobe");

endmodule

// File: rtl/breakpoint_unit.sv
`timescale 1ns/1ps

module breakpoint_unit (
    input  logic           clk,
    input  logic           rst,
    bp_ctrl_if.unit        ctl,
    input  pdu_pkg::addr_t current_pc,
    input  pdu_pkg::addr_t next_pc,
    output pdu_pkg::addr_t bp_addr
);
    import pdu_pkg::*;

    addr_t   bp_q;
    nibble_t nib;
    logic    is_hex;

    always_comb begin
        is_hex = hex_value(ctl.digit, nib);
    end

    always_ff @(posedge clk) begin
        if (rst || ctl.bp_clear) begin
            bp_q <= '0;
        end else if (ctl.bp_capture) begin
            // step stops one instruction ahead
            bp_q <= next_pc;
        end else if (ctl.bp_shift && is_hex) begin
            bp_q <= {bp_q[27:0], nib};
        end
    end

    assign ctl.bp_hit = (current_pc == bp_q);
    assign bp_addr    = bp_q;

endmodule

// File: rtl/cpu_clk_gen.sv
`timescale 1ns/1ps
`include "pdu_config.svh"

module cpu_clk_gen (
    input  logic clk,
    input  logic rst,
    input  logic run_en,
    output logic cpu_clk
);
    localparam int PERIOD_LAST = 2 * `CPU_CLK_HALF;
    localparam int CNT_W = $clog2(PERIOD_LAST + 1);

    logic [CNT_W-1:0] cnt;

    // A started period runs to the end even if run_en drops
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            cpu_clk <= 1'b0;
        end else if (run_en || cnt != '0) begin
            if (cnt == CNT_W'(PERIOD_LAST)) begin
                cnt     <= '0;
                cpu_clk <= 1'b0;
            end else begin
                cnt     <= cnt + 1'b1;
                cpu_clk <= (cnt < CNT_W'(`CPU_CLK_HALF));
            end
        end
    end

    a_idle_low: assert property (@(posedge clk) disable iff (rst)
        (cnt == '0) |-> !cpu_clk)
        else $error("cpu_clk high between periods");

endmodule

// File: rtl/pdu_ctrl.sv
`timescale 1ns/1ps

module pdu_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           din_vld,
    input  pdu_pkg::char_t din_data,
    input  logic           ebreak,
    input  pdu_pkg::addr_t current_pc,
    input  pdu_pkg::addr_t next_pc,
    output pdu_pkg::addr_t check_addr,
    output pdu_pkg::addr_t bp_addr,
    output logic           cpu_clk,
    output logic           cpu_rst,
    output pdu_pkg::led_t  led
);
    logic run_en;

    addr_ctrl_if addr_ctl ();
    bp_ctrl_if   bp_ctl ();

    pdu_cmd_fsm u_cmd_fsm (
        .clk        (clk),
        .rst        (rst),
        .din_vld    (din_vld),
        .din_data   (din_data),
        .ebreak     (ebreak),
        .current_pc (current_pc),
        .addr       (addr_ctl.fsm),
        .bp         (bp_ctl.fsm),
        .run_en     (run_en),
        .cpu_rst    (cpu_rst),
        .led        (led)
    );

    check_addr_unit u_check_addr (
        .clk        (clk),
        .rst        (rst),
        .ctl        (addr_ctl.unit),
        .check_addr (check_addr)
    );

    breakpoint_unit u_breakpoint (
        .clk        (clk),
        .rst        (rst),
        .ctl        (bp_ctl.unit),
        .current_pc (current_pc),
        .next_pc    (next_pc),
        .bp_addr    (bp_addr)
    );

    cpu_clk_gen u_cpu_clk (
        .clk     (clk),
        .rst     (rst),
        .run_en  (run_en),
        .cpu_clk (cpu_clk)
    );

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

// Free-running testbench clock, 4 ns period
module tb_clk_gen #(
    parameter int HALF_NS = 2
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #(HALF_NS) clk = ~clk;

endmodule

// File: verification/pdu_ctrl_tb.sv
`timescale 1ns/1ps

module pdu_ctrl_tb;
    import pdu_pkg::*;

    localparam addr_t START_PC   = 32'h0000_3000;
    localparam addr_t NO_EBREAK  = 32'hdead_beef;
    localparam int    WAIT_LIMIT = 2000;
    localparam int    SEED       = 73;

    logic  clk;
    logic  rst;
    logic  din_vld;
    char_t din_data;
    logic  ebreak;
    addr_t current_pc;
    addr_t next_pc;
    addr_t check_addr;
    addr_t bp_addr;
    logic  cpu_clk;
    logic  cpu_rst;
    led_t  led;

    // CPU model state
    addr_t pc = START_PC;
    logic  cpu_clk_q = 1'b0;
    addr_t ebreak_at;

    int    errors;
    logic  timed_out;

    // Command table, one entry per row in each queue
    string row_name[$];
    string row_cmd[$];
    addr_t row_ebreak[$];
    addr_t row_check[$];
    addr_t row_bp[$];
    addr_t row_pc[$];
    int    row_hold[$];

    tb_clk_gen u_clk (.clk(clk));

    pdu_ctrl UUT (
        .clk        (clk),
        .rst        (rst),
        .din_vld    (din_vld),
        .din_data   (din_data),
        .ebreak     (ebreak),
        .current_pc (current_pc),
        .next_pc    (next_pc),
        .check_addr (check_addr),
        .bp_addr    (bp_addr),
        .cpu_clk    (cpu_clk),
        .cpu_rst    (cpu_rst),
        .led        (led)
    );

    // PC steps by 4 on each cpu_clk rise and cpu_rst reloads it
    always @(posedge clk) begin
        cpu_clk_q <= cpu_clk;
        if (rst || cpu_rst) begin
            pc <= START_PC;
        end else if (cpu_clk && !cpu_clk_q) begin
            pc <= pc + 32'd4;
        end
    end

    assign current_pc = pc;
    assign next_pc    = pc + 32'd4;
    assign ebreak     = (pc == ebreak_at);

    function automatic void add_row(input string name, input string cmd, input addr_t ebr,
                                    input addr_t chk, input addr_t bpv, input addr_t pcv,
                                    input int hold);
        row_name.push_back(name);
        row_cmd.push_back(cmd);
        row_ebreak.push_back(ebr);
        row_check.push_back(chk);
        row_bp.push_back(bpv);
        row_pc.push_back(pcv);
        row_hold.push_back(hold);
    endfunction

    function automatic void build_table();
        add_row("ck_abs", "ck 1a;", NO_EBREAK, 32'h1a, 32'h0, 32'h3000, 0);
        add_row("ck_rf", "ck1 4;", NO_EBREAK, 32'h1004, 32'h0, 32'h3000, 0);
        add_row("ck_dm_skip", "ck2g8;", NO_EBREAK, 32'h2008, 32'h0, 32'h3000, 0);
        add_row("ck_stat", "ck03 2;", NO_EBREAK, 32'h62, 32'h0, 32'h3000, 0);
        add_row("add", "add;", NO_EBREAK, 32'h63, 32'h0, 32'h3000, 0);
        add_row("sub", "sub;", NO_EBREAK, 32'h62, 32'h0, 32'h3000, 0);
        add_row("bp_load", "bp3010;", NO_EBREAK, 32'h62, 32'h3010, 32'h3000, 0);
        add_row("bad_ck", "cx", NO_EBREAK, 32'h62, 32'h3010, 32'h3000, 0);
        add_row("bad_bp", "bq", NO_EBREAK, 32'h62, 32'h3010, 32'h3000, 0);
        add_row("cpu_rst", "rst;", NO_EBREAK, 32'h62, 32'h3010, 32'h3000, 0);
        add_row("run_bp", "run;", NO_EBREAK, 32'h62, 32'h3010, 32'h3010, 0);
        // Step stops one instruction later
        add_row("step", "step;", NO_EBREAK, 32'h62, 32'h3014, 32'h3014, 0);
        add_row("bp_clear", "bp0;", NO_EBREAK, 32'h62, 32'h0, 32'h3014, 0);
        add_row("cpu_rst_again", "rst;", NO_EBREAK, 32'h62, 32'h0, 32'h3000, 0);
        add_row("run_ebreak", "run;", 32'h3008, 32'h62, 32'h0, 32'h3008, 300);
    endfunction

    task automatic check_value(input string test, input string what, input addr_t expected,
                               input addr_t actual);
        assert (actual == expected) else begin
            errors++;
            $display("MISMATCH %s %s expected %h actual %h", test, what, expected, actual);
        end
    endtask

    // Called at 1 ns after a rising edge
    task automatic send_byte(input char_t c);
        din_data = c;
        din_vld  = 1'b1;
        @(posedge clk);
        #1;
        din_vld = 1'b0;
    endtask

    task automatic send_cmd(input string cmd);
        int unsigned gap;
        for (int k = 0; k < cmd.len(); k++) begin
            if (k > 0) begin
                gap = $urandom % 4;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
            send_byte(cmd.getc(k));
        end
    endtask

    task automatic wait_idle(input string test);
        int n;
        n = 0;
        while (!led[4] && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!led[4]) begin
            errors++;
            timed_out = 1'b1;
            $display("%s: parser did not return to idle within %0d cycles", test, WAIT_LIMIT);
        end
    endtask

    initial begin
        int i;
        errors    = 0;
        timed_out = 1'b0;
        rst       = 1'b1;
        din_vld   = 1'b0;
        din_data  = '0;
        ebreak_at = NO_EBREAK;
        void'($urandom(SEED));
        build_table();

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_value("reset", "cpu_rst", 32'd0, addr_t'(cpu_rst));
        check_value("reset", "cpu_clk", 32'd0, addr_t'(cpu_clk));
        check_value("reset", "check_addr", 32'd0, check_addr);
        check_value("reset", "bp_addr", 32'd0, bp_addr);
        check_value("reset", "led", 32'h10, addr_t'(led));

        i = 0;
        while (i < row_name.size() && !timed_out) begin
            ebreak_at = row_ebreak[i];
            send_cmd(row_cmd[i]);
            wait_idle(row_name[i]);
            if (!timed_out) begin
                check_value(row_name[i], "check_addr", row_check[i], check_addr);
                check_value(row_name[i], "bp_addr", row_bp[i], bp_addr);
                check_value(row_name[i], "pc", row_pc[i], pc);
                check_value(row_name[i], "led", 32'h10, addr_t'(led));
                // PC must stay put once the run has stopped
                if (row_hold[i] > 0) begin
                    repeat (row_hold[i]) begin
                        @(posedge clk);
                        #1;
                    end
                    check_value({row_name[i], "_hold"}, "pc", row_pc[i], pc);
                end
            end
            i++;
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+rtl
rtl/pdu_pkg.sv
rtl/pdu_ifs.sv
rtl/pdu_cmd_fsm.sv
rtl/check_addr_unit.sv
rtl/breakpoint_unit.sv
rtl/cpu_clk_gen.sv
rtl/pdu_ctrl.sv
verification/tb_clk_gen.sv
verification/pdu_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pdu_ctrl_tb
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f project.f

# Pass only if the simulation prints the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir
